//--- eeprom_ctrl.f
verilog/eeprom_pkg.sv
verilog/i2c_bit_engine.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl.sv
sim/eeprom_model.sv
sim/tb_eeprom_ctrl.sv

//--- sim/eeprom_model.sv
`timescale 1ns/10ps

module eeprom_model
    import eeprom_pkg::*;
(
    input  logic scl,
    inout  wire  sda,
    input  logic nack_addr
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_t;

    eeprom_data_t mem [0:2047];
    model_state_t state;
    model_state_t next_state; // taken after the ack bit
    eeprom_data_t shreg;
    logic [2:0]   block;
    logic [7:0]   offset;
    int           bit_cnt;
    logic         ack_bit;    // device owns the ninth bit
    logic         drive_low;
    logic         scl_q;
    logic         sda_q;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;
        state      = M_IDLE;
        next_state = M_IDLE;
        bit_cnt    = 0;
        ack_bit    = 1'b0;
        drive_low  = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
    end

    // decides on the ack once a byte is in
    task automatic take_byte;
        case (state)
            M_CTRL:
                if (shreg[7:4] != CTRL_PREFIX)
                    state = M_IDLE; // not addressed
                else
                begin
                    block      = shreg[3:1];
                    next_state = shreg[0] ? M_RDATA : M_ADDR;
                    ack_bit    = 1'b1;
                end
            M_ADDR:
                if (nack_addr)
                    state = M_IDLE;
                else
                begin
                    offset     = shreg;
                    next_state = M_WDATA;
                    ack_bit    = 1'b1;
                end
            default:
            begin
                mem[{block, offset}] = shreg; // no internal write cycle
                next_state = M_WDATA;
                ack_bit    = 1'b1;
            end
        endcase
        drive_low = ack_bit;
    endtask

    task automatic sample_on_rise;
        if (state == M_RDATA)
        begin
            if (bit_cnt < 8)
                bit_cnt++;
            else
                state = M_IDLE; // single byte reads only
        end
        else if (state != M_IDLE && !ack_bit && bit_cnt < 8)
        begin
            shreg = {shreg[6:0], sda};
            bit_cnt++;
        end
    endtask

    task automatic drive_on_fall;
        if (ack_bit)
        begin
            ack_bit   = 1'b0;
            drive_low = 1'b0;
            bit_cnt   = 0;
            state     = next_state;
            if (state == M_RDATA)
            begin
                shreg     = mem[{block, offset}];
                drive_low = ~shreg[7];
            end
        end
        else if (state == M_RDATA)
        begin
            if (bit_cnt < 8)
                drive_low = ~shreg[7 - bit_cnt];
            else
                drive_low = 1'b0; // master ack slot
        end
        else if (state != M_IDLE && bit_cnt == 8)
            take_byte();
    endtask

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            state     = M_CTRL; // start or repeated start
            bit_cnt   = 0;
            ack_bit   = 1'b0;
            drive_low = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            state     = M_IDLE; // stop
            ack_bit   = 1'b0;
            drive_low = 1'b0;
        end
        else if (scl_q === 1'b0 && scl === 1'b1)
            sample_on_rise();
        else if (scl_q === 1'b1 && scl === 1'b0)
            drive_on_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- sim/tb_eeprom_ctrl.sv
`timescale 1ns/10ps

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int XACT_LIMIT = 1000;            // longest transaction is ~650 cycles
    localparam int MAX_CYCLES = 40 * XACT_LIMIT; // 32 transactions plus idle test

    logic         CLK;
    logic         RESET;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    eeprom_addr_t wb_adr;
    eeprom_data_t wb_dat_i;
    eeprom_data_t wb_dat_o;
    logic         wb_ack;
    logic         wb_err;
    wire          scl;
    wire          sda;
    logic         nack_addr;

    eeprom_data_t ref_mem [0:2047]; // expected array contents
    logic         written [0:2047];
    logic [31:0]  rng;
    int           n_pass;
    int           n_err;
    int           cycles;

    pullup (sda);

    eeprom_ctrl i_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .wb_err   (wb_err),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_model i_model (
        .scl       (scl),
        .sda       (sda),
        .nack_addr (nack_addr)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_data(input string name, input eeprom_data_t got,
                              input eeprom_data_t exp);
        if (got === exp)
            n_pass++;
        else
        begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
            n_err++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got === exp)
            n_pass++;
        else
        begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
            n_err++;
        end
    endtask

    task automatic check_model_byte(input eeprom_addr_t addr, input eeprom_data_t exp);
        check_data($sformatf("i_model.mem[%h]", addr), i_model.mem[addr], exp);
    endtask

    task automatic report_test(input string name, input int err0);
        if (n_err == err0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, n_err - err0);
    endtask

    // ack or err sampled mid cycle before the host lets go
    task automatic await_reply(output logic ack, output logic err, output eeprom_data_t rdata);
        int n;
        n = 0;
        do
        begin
            @(negedge CLK);
            n++;
        end
        while (!wb_ack && !wb_err && n < XACT_LIMIT);
        ack    = wb_ack;
        err    = wb_err;
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!ack && !err)
        begin
            $display("no wb_ack or wb_err within %0d cycles at %0t ns", XACT_LIMIT, $time);
            n_err++;
        end
    endtask

    task automatic wb_transfer(input logic we, input eeprom_addr_t addr,
                               input eeprom_data_t wdata, output eeprom_data_t rdata,
                               output logic ack, output logic err);
        @(negedge CLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_i = wdata;
        await_reply(ack, err, rdata);
    endtask

    task automatic wb_write(input eeprom_addr_t addr, input eeprom_data_t data,
                            output logic ack, output logic err);
        eeprom_data_t rd_ignored;
        wb_transfer(1'b1, addr, data, rd_ignored, ack, err);
    endtask

    task automatic wb_read(input eeprom_addr_t addr, output eeprom_data_t data,
                           output logic ack, output logic err);
        wb_transfer(1'b0, addr, 8'h00, data, ack, err);
    endtask

    task automatic write_and_check(input eeprom_addr_t addr, input eeprom_data_t data);
        logic ack;
        logic err;
        wb_write(addr, data, ack, err);
        check_bit("wb_ack", ack, 1'b1);
        check_bit("wb_err", err, 1'b0);
        ref_mem[addr] = data;
        written[addr] = 1'b1;
        check_model_byte(addr, data);
    endtask

    task automatic read_and_check(input eeprom_addr_t addr, input eeprom_data_t exp);
        eeprom_data_t rd;
        logic         ack;
        logic         err;
        wb_read(addr, rd, ack, err);
        check_bit("wb_ack", ack, 1'b1);
        check_bit("wb_err", err, 1'b0);
        check_data("wb_dat_o", rd, exp);
    endtask

    task automatic test_idle;
        int err0;
        err0 = n_err;
        repeat (100)
        begin
            @(negedge CLK);
            check_bit("wb_ack", wb_ack, 1'b0);
            check_bit("wb_err", wb_err, 1'b0);
            check_bit("scl", scl, 1'b1);
            check_bit("sda", sda, 1'b1);
        end
        report_test("idle after reset", err0);
    endtask

    task automatic test_write_read;
        int err0;
        err0 = n_err;
        rng = xorshift32(rng);
        write_and_check(11'h3A7, rng[7:0]);
        read_and_check(11'h3A7, rng[7:0]);
        report_test("write then read", err0);
    endtask

    // block number follows the index so all eight blocks are hit
    task automatic test_blocks;
        eeprom_addr_t addrs [12];
        int           err0;
        err0 = n_err;
        for (int i = 0; i < 12; i++)
        begin
            rng = xorshift32(rng);
            addrs[i] = {i[2:0], rng[7:0]};
            write_and_check(addrs[i], rng[23:16]);
        end
        for (int i = 0; i < 12; i++)
            read_and_check(addrs[i], ref_mem[addrs[i]]);
        report_test("random blocks", err0);
    endtask

    task automatic test_unwritten;
        eeprom_addr_t addr;
        int           err0;
        err0 = n_err;
        addr = 11'h5A5;
        while (written[addr])
            addr++;
        read_and_check(addr, 8'hFF); // erased state
        report_test("unwritten location", err0);
    endtask

    task automatic test_nack;
        eeprom_data_t rd;
        eeprom_data_t wdata;
        logic         ack;
        logic         err;
        int           err0;
        err0 = n_err;
        rng = xorshift32(rng);
        wdata = ref_mem[11'h2C4] ^ (rng[7:0] | 8'h01); // never the stored byte
        nack_addr = 1'b1;
        wb_write(11'h2C4, wdata, ack, err);
        check_bit("wb_err", err, 1'b1);
        check_bit("wb_ack", ack, 1'b0);
        check_model_byte(11'h2C4, ref_mem[11'h2C4]);
        wb_read(11'h2C4, rd, ack, err);
        check_bit("wb_err", err, 1'b1);
        check_bit("wb_ack", ack, 1'b0);
        check_bit("scl", scl, 1'b1); // bus released after the stop
        check_bit("sda", sda, 1'b1);
        nack_addr = 1'b0;
        read_and_check(11'h2C4, ref_mem[11'h2C4]);
        report_test("address nack", err0);
    endtask

    task automatic test_stb_drop;
        eeprom_data_t rd;
        eeprom_data_t wdata;
        logic         ack;
        logic         err;
        int           err0;
        err0 = n_err;
        rng = xorshift32(rng);
        wdata = ref_mem[11'h6E1] ^ (rng[7:0] | 8'h01); // differs from the old byte
        @(negedge CLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = 11'h6E1;
        wb_dat_i = wdata;
        repeat (20) @(negedge CLK);
        wb_stb = 1'b0; // host walks away mid transfer
        wb_cyc = 1'b0;
        await_reply(ack, err, rd);
        check_bit("wb_ack", ack, 1'b1);
        check_bit("wb_err", err, 1'b0);
        ref_mem[11'h6E1] = wdata;
        written[11'h6E1] = 1'b1;
        check_model_byte(11'h6E1, wdata);
        read_and_check(11'h6E1, wdata);
        report_test("stb dropped", err0);
    endtask

    initial
    begin
        RESET     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        nack_addr = 1'b0;
        n_pass    = 0;
        n_err     = 0;
        cycles    = 0;
        rng       = 32'd44054;
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = 8'hFF;
            written[i] = 1'b0;
        end
        repeat (2) @(negedge CLK);
        RESET = 1'b0;

        test_idle();
        test_write_read();
        test_blocks();
        test_unwritten();
        test_nack();
        test_stb_drop();

        $display("checks passed: %0d, errors: %0d", n_pass, n_err);
        if (n_err == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- verilog/eeprom_ctrl.sv
`timescale 1ns/10ps

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  eeprom_addr_t wb_adr,
    input  eeprom_data_t wb_dat_i,
    output eeprom_data_t wb_dat_o,
    output logic         wb_ack,
    output logic         wb_err,
    output logic         scl,
    inout  wire          sda
);

    bus_cmd_t     cmd;
    logic         cmd_valid;
    eeprom_data_t tx_byte;
    logic         master_ack;
    logic         cmd_done;
    eeprom_data_t rx_byte;
    logic         slave_ack;
    logic         sda_oe;
    logic         sda_in;

    // open drain driver with the pull-up outside the chip
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_sequencer i_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack)
    );

    i2c_bit_engine i_bit (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .master_ack (master_ack),
        .cmd_done   (cmd_done),
        .rx_byte    (rx_byte),
        .slave_ack  (slave_ack),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

//--- verilog/eeprom_pkg.sv
package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t; // [10:8] block, [7:0] offset
    typedef logic [7:0]  eeprom_data_t;

    // CMD_START doubles as repeated start
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE,
        CMD_READ
    } bus_cmd_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_WR,
        ST_ADDR,
        ST_DATA_WR,
        ST_RESTART,
        ST_CTRL_RD,
        ST_DATA_RD,
        ST_STOP,
        ST_DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        BIT_IDLE,
        BIT_START,
        BIT_SHIFT,
        BIT_ACK,
        BIT_STOP
    } bit_state_t;

    localparam logic [3:0] CTRL_PREFIX = 4'b1010; // 24Cxx device type code

    localparam int SCL_QUARTER = 4; // CLK cycles per quarter SCL period
    localparam int QCNT_W      = $clog2(SCL_QUARTER);
    localparam logic [QCNT_W-1:0] QCNT_LAST = QCNT_W'(SCL_QUARTER - 1);

endpackage

//--- verilog/eeprom_sequencer.sv
`timescale 1ns/10ps

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  eeprom_addr_t wb_adr,
    input  eeprom_data_t wb_dat_i,
    output eeprom_data_t wb_dat_o,
    output logic         wb_ack,
    output logic         wb_err,
    output bus_cmd_t     cmd,
    output logic         cmd_valid,
    output eeprom_data_t tx_byte,
    output logic         master_ack,
    input  logic         cmd_done,
    input  eeprom_data_t rx_byte,
    input  logic         slave_ack
);

    seq_state_t   state;
    eeprom_addr_t addr_q;
    eeprom_data_t data_q;
    eeprom_data_t rd_q;
    logic         we_q;
    logic         err_q;  // device refused a byte

    assign cmd_valid  = (state != ST_IDLE) && (state != ST_DONE);
    assign wb_ack     = (state == ST_DONE) && !err_q;
    assign wb_err     = (state == ST_DONE) && err_q;
    assign master_ack = 1'b0; // single byte read ends with NACK

    always_comb
    begin
        cmd     = CMD_WRITE;
        tx_byte = 8'h00;
        case (state)
            ST_START,
            ST_RESTART: cmd = CMD_START;
            ST_CTRL_WR: tx_byte = {CTRL_PREFIX, addr_q[10:8], 1'b0};
            ST_ADDR:    tx_byte = addr_q[7:0];
            ST_DATA_WR: tx_byte = data_q;
            ST_CTRL_RD: tx_byte = {CTRL_PREFIX, addr_q[10:8], 1'b1};
            ST_DATA_RD: cmd = CMD_READ;
            ST_STOP:    cmd = CMD_STOP;
            default:    cmd = CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (wb_cyc && wb_stb)
                    begin
                        err_q <= 1'b0;
                        state <= ST_START;
                    end
                ST_START:
                    if (cmd_done)
                        state <= ST_CTRL_WR;
                ST_CTRL_WR,
                ST_ADDR,
                ST_DATA_WR,
                ST_CTRL_RD:
                    if (cmd_done)
                    begin
                        if (!slave_ack)
                        begin
                            err_q <= 1'b1;
                            state <= ST_STOP;
                        end
                        else if (state == ST_CTRL_WR)
                            state <= ST_ADDR;
                        else if (state == ST_ADDR)
                            state <= we_q ? ST_DATA_WR : ST_RESTART;
                        else if (state == ST_CTRL_RD)
                            state <= ST_DATA_RD;
                        else
                            state <= ST_STOP;
                    end
                ST_RESTART:
                    if (cmd_done)
                        state <= ST_CTRL_RD;
                ST_DATA_RD:
                    if (cmd_done)
                        state <= ST_STOP;
                ST_STOP:
                    if (cmd_done)
                        state <= ST_DONE;
                default:
                    state <= ST_IDLE; // ack or err for one cycle
            endcase
        end
    end

    // request latch and read data
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && wb_cyc && wb_stb)
        begin
            addr_q <= wb_adr;
            data_q <= wb_dat_i;
            we_q   <= wb_we;
        end
        if (state == ST_DATA_RD && cmd_done)
            rd_q <= rx_byte;
        if (state == ST_STOP && cmd_done && !we_q && !err_q)
            wb_dat_o <= rd_q;
    end

endmodule

//--- verilog/i2c_bit_engine.sv
`timescale 1ns/10ps

module i2c_bit_engine
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  bus_cmd_t     cmd,
    input  logic         cmd_valid,
    input  eeprom_data_t tx_byte,
    input  logic         master_ack,
    output logic         cmd_done,
    output eeprom_data_t rx_byte,
    output logic         slave_ack,
    output logic         scl,
    output logic         sda_oe,
    input  logic         sda_in
);

    bit_state_t        state;
    logic [QCNT_W-1:0] q_cnt;
    logic [1:0]        phase;    // quarter of the current SCL period
    logic [2:0]        bit_cnt;
    logic              is_read;
    logic              scl_idle; // level SCL rests at between commands
    eeprom_data_t      sh;
    logic              tick;
    logic              accept;

    assign tick    = (q_cnt == QCNT_LAST);
    // cmd_valid is still up for the finished command during cmd_done
    assign accept  = (state == BIT_IDLE) && cmd_valid && !cmd_done;
    assign rx_byte = sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= BIT_IDLE;
            q_cnt    <= '0;
            phase    <= 2'd0;
            bit_cnt  <= 3'd0;
            is_read  <= 1'b0;
            scl_idle <= 1'b1;
            cmd_done <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (state == BIT_IDLE)
            begin
                if (accept)
                begin
                    q_cnt   <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= 3'd0;
                    is_read <= (cmd == CMD_READ);
                    case (cmd)
                        CMD_START: state <= BIT_START;
                        CMD_STOP:  state <= BIT_STOP;
                        default:   state <= BIT_SHIFT;
                    endcase
                end
            end
            else
            begin
                q_cnt <= tick ? '0 : q_cnt + 1'b1;
                if (tick)
                begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3)
                    begin
                        case (state)
                            BIT_SHIFT:
                            begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7)
                                    state <= BIT_ACK;
                            end
                            BIT_STOP:
                            begin
                                state    <= BIT_IDLE;
                                cmd_done <= 1'b1;
                                scl_idle <= 1'b1; // bus free again
                            end
                            default: // start or ack bit done
                            begin
                                state    <= BIT_IDLE;
                                cmd_done <= 1'b1;
                                scl_idle <= 1'b0;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // shift register and ack sample
    always_ff @(posedge CLK)
    begin
        if (accept)
            sh <= tx_byte;
        else if (state == BIT_SHIFT && tick)
        begin
            if (is_read && phase == 2'd1)
                sh <= {sh[6:0], sda_in};   // sample mid high
            else if (!is_read && phase == 2'd3)
                sh <= {sh[6:0], 1'b0};     // next bit while scl low
        end

        if (state == BIT_ACK && tick && phase == 2'd1 && !is_read)
            slave_ack <= ~sda_in;
    end

    // scl high in phases 1 and 2 of a data bit
    always_comb
    begin
        case (state)
            BIT_START:
            begin
                scl    = phase[0] ^ phase[1];
                sda_oe = phase[1];               // sda falls in phase 2
            end
            BIT_STOP:
            begin
                scl    = (phase != 2'd0);
                sda_oe = ~phase[1];              // sda rises in phase 2
            end
            BIT_SHIFT:
            begin
                scl    = phase[0] ^ phase[1];
                sda_oe = !is_read && !sh[7];
            end
            BIT_ACK:
            begin
                scl    = phase[0] ^ phase[1];
                sda_oe = is_read && master_ack;  // master ack drives low
            end
            default:
            begin
                scl    = scl_idle;
                sda_oe = 1'b0;
            end
        endcase
    end

endmodule
